/* hw/rvCorePkg.sv */
`default_nettype none

package rvCorePkg;

  // data path and storage sizes
  localparam int xlen = 64;
  localparam int instrW = 32;
  localparam int memBytes = 2048;
  localparam int regCount = 32;
  localparam int memAddrW = $clog2(memBytes);
  localparam int regAddrW = $clog2(regCount);
  localparam int bytesPerWord = xlen / 8;

  // major opcodes of the supported formats
  localparam logic [6:0] rvOpReg = 7'b0110011;
  localparam logic [6:0] rvOpImm = 7'b0010011;
  localparam logic [6:0] rvOpLui = 7'b0110111;
  localparam logic [6:0] rvOpLoad = 7'b0000011;
  localparam logic [6:0] rvOpStore = 7'b0100011;

  // funct7 for the base and the alternate (SUB) register ops
  localparam logic [6:0] funct7Base = 7'b0000000;
  localparam logic [6:0] funct7Alt = 7'b0100000;

  typedef enum logic [2:0] {
    opReg,
    opImm,
    opLui,
    opLoad,
    opStore,
    opIllegal
  } opClassE;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluSltu
  } aluOpE;

  // encoding matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    sizeByte = 2'd0,
    sizeHalf = 2'd1,
    sizeWord = 2'd2,
    sizeDouble = 2'd3
  } memSizeE;

  typedef struct packed {
    logic                valid;
    opClassE             opClass;
    aluOpE               aluOp;
    memSizeE             memSize;
    logic                loadUnsigned;
    logic [regAddrW-1:0] rs1;
    logic [regAddrW-1:0] rs2;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     imm;
  } decodedT;

  typedef struct packed {
    logic                valid;
    opClassE             opClass;
    memSizeE             memSize;
    logic                loadUnsigned;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     aluResult;
    logic [xlen-1:0]     storeData;
  } executedT;

  typedef struct packed {
    logic                valid;
    logic                illegal;
    logic                rdWe;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     value;
  } retireT;

  typedef struct packed {
    logic                we;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     data;
  } writebackT;

endpackage

`default_nettype wire

/* hw/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import rvCorePkg::*; (
  input  logic              clk,
  input  logic              rstN,
  input  logic              instrValid,
  input  logic [instrW-1:0] instr,
  output decodedT           decoded
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  decodedT    next;

  // standard RV field positions
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    next = '0;
    next.valid = instrValid;
    next.opClass = opIllegal;
    next.aluOp = aluAdd;
    next.memSize = memSizeE'(funct3[1:0]);
    next.rs1 = instr[19:15];
    next.rs2 = instr[24:20];
    next.rd = instr[11:7];
    // I-type immediate by default
    next.imm = {{(xlen-12){instr[31]}}, instr[31:20]};
    case (opcode)
      rvOpReg: begin
        next.opClass = opReg;
        if (funct7 == funct7Base) begin
          case (funct3)
            3'b000: next.aluOp = aluAdd;
            3'b010: next.aluOp = aluSlt;
            3'b011: next.aluOp = aluSltu;
            3'b100: next.aluOp = aluXor;
            3'b110: next.aluOp = aluOr;
            3'b111: next.aluOp = aluAnd;
            default: next.opClass = opIllegal;
          endcase
        end else if (funct7 == funct7Alt && funct3 == 3'b000) begin
          next.aluOp = aluSub;
        end else begin
          next.opClass = opIllegal;
        end
      end
      rvOpImm: begin
        next.opClass = opImm;
        // no SLTIU and no shifts here
        case (funct3)
          3'b000: next.aluOp = aluAdd;
          3'b010: next.aluOp = aluSlt;
          3'b100: next.aluOp = aluXor;
          3'b110: next.aluOp = aluOr;
          3'b111: next.aluOp = aluAnd;
          default: next.opClass = opIllegal;
        endcase
      end
      rvOpLui: begin
        next.opClass = opLui;
        next.imm = {{(xlen-32){instr[31]}}, instr[31:12], 12'b0};
      end
      rvOpLoad: begin
        // funct3 111 has no load
        next.opClass = (funct3 == 3'b111) ? opIllegal : opLoad;
        next.loadUnsigned = funct3[2];
      end
      rvOpStore: begin
        next.opClass = funct3[2] ? opIllegal : opStore;
        // S-type immediate, rd field holds imm[4:0]
        next.imm = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
        next.rd = '0;
      end
      default: begin
        next.opClass = opIllegal;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      decoded <= '0;
    end else begin
      decoded <= next;
    end
  end

endmodule

`default_nettype wire

/* hw/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile import rvCorePkg::*; (
  input  logic                clk,
  input  logic                rstN,
  input  logic [regAddrW-1:0] rs1,
  input  logic [regAddrW-1:0] rs2,
  output logic [xlen-1:0]     rs1Data,
  output logic [xlen-1:0]     rs2Data,
  input  writebackT           writeback
);

  // x0 has no storage
  logic [xlen-1:0] regs [1:regCount-1];

  // write-first read, the result stage commit is visible at once
  function automatic logic [xlen-1:0] readPort(input logic [regAddrW-1:0] addr);
    if (addr == '0) begin
      return '0;
    end else if (writeback.we && writeback.rd == addr) begin
      return writeback.data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs1Data = readPort(rs1);
    rs2Data = readPort(rs2);
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (writeback.we && writeback.rd != '0) begin
      regs[writeback.rd] <= writeback.data;
    end
  end

endmodule

`default_nettype wire

/* hw/aluExecute.sv */
`timescale 1ns/1ps
`default_nettype none

module aluExecute import rvCorePkg::*; (
  input  logic                clk,
  input  logic                rstN,
  input  decodedT             decoded,
  output logic [regAddrW-1:0] rs1,
  output logic [regAddrW-1:0] rs2,
  input  logic [xlen-1:0]     rs1Data,
  input  logic [xlen-1:0]     rs2Data,
  output executedT            executed
);

  logic [xlen-1:0] opB;
  logic [xlen-1:0] result;

  // operand fetch happens in this stage
  assign rs1 = decoded.rs1;
  assign rs2 = decoded.rs2;

  always_comb begin
    // only register ops take rs2 as second operand
    opB = (decoded.opClass == opReg) ? rs2Data : decoded.imm;
    case (decoded.aluOp)
      aluAdd: result = rs1Data + opB;
      aluSub: result = rs1Data - opB;
      aluAnd: result = rs1Data & opB;
      aluOr: result = rs1Data | opB;
      aluXor: result = rs1Data ^ opB;
      aluSlt: result = {{(xlen-1){1'b0}}, $signed(rs1Data) < $signed(opB)};
      aluSltu: result = {{(xlen-1){1'b0}}, rs1Data < opB};
      default: result = '0;
    endcase
    // upper immediate already shifted by the decoder
    if (decoded.opClass == opLui) begin
      result = decoded.imm;
    end
  end

  // loads and stores get the address from the add path
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      executed <= '0;
    end else begin
      executed.valid <= decoded.valid;
      executed.opClass <= decoded.opClass;
      executed.memSize <= decoded.memSize;
      executed.loadUnsigned <= decoded.loadUnsigned;
      executed.rd <= decoded.rd;
      executed.aluResult <= result;
      executed.storeData <= rs2Data;
    end
  end

endmodule

`default_nettype wire

/* hw/dataMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMemory import rvCorePkg::*; (
  input  logic                clk,
  input  logic                we,
  input  memSizeE             size,
  input  logic [memAddrW-1:0] addr,
  input  logic [xlen-1:0]     writeData,
  output logic [xlen-1:0]     readData
);

  logic [7:0]      mem [memBytes];
  logic [3:0]      byteCount;
  logic [xlen-1:0] alignedData;

  // big-endian read, lowest address lands in the top byte
  always_comb begin
    for (int i = 0; i < bytesPerWord; i++) begin
      // address arithmetic wraps at the array end
      readData[xlen-1-8*i -: 8] = mem[addr + memAddrW'(i)];
    end
  end

  always_comb begin
    case (size)
      sizeByte: byteCount = 4'd1;
      sizeHalf: byteCount = 4'd2;
      sizeWord: byteCount = 4'd4;
      default: byteCount = 4'd8;
    endcase
    // move the low bytes to the top so byte i goes to addr + i
    alignedData = writeData << (8 * (bytesPerWord - byteCount));
  end

  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < bytesPerWord; i++) begin
        if (i < byteCount) begin
          mem[addr + memAddrW'(i)] <= alignedData[xlen-1-8*i -: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/resultStage.sv */
`timescale 1ns/1ps
`default_nettype none

module resultStage import rvCorePkg::*; (
  input  logic                clk,
  input  logic                rstN,
  input  executedT            executed,
  output logic                memWe,
  output memSizeE             memSize,
  output logic [memAddrW-1:0] memAddr,
  output logic [xlen-1:0]     memWriteData,
  input  logic [xlen-1:0]     memReadData,
  output writebackT           writeback,
  output retireT              retire
);

  logic            fill;
  logic            isIllegal;
  logic [xlen-1:0] loadValue;
  logic [xlen-1:0] retireValue;

  // address taken modulo memory size
  assign memAddr = executed.aluResult[memAddrW-1:0];
  assign memSize = executed.memSize;
  assign memWriteData = executed.storeData;
  assign memWe = executed.valid && executed.opClass == opStore;

  assign isIllegal = executed.opClass == opIllegal;

  // loaded data always sits at the top of the read word
  assign fill = ~executed.loadUnsigned & memReadData[xlen-1];

  always_comb begin
    case (executed.memSize)
      sizeByte: loadValue = {{(xlen-8){fill}}, memReadData[xlen-1 -: 8]};
      sizeHalf: loadValue = {{(xlen-16){fill}}, memReadData[xlen-1 -: 16]};
      sizeWord: loadValue = {{(xlen-32){fill}}, memReadData[xlen-1 -: 32]};
      default: loadValue = memReadData;
    endcase
  end

  always_comb begin
    writeback.rd = executed.rd;
    writeback.data = (executed.opClass == opLoad) ? loadValue : executed.aluResult;
    // stores and illegal ops never write, nor does x0
    writeback.we = executed.valid && executed.rd != '0 &&
                   executed.opClass inside {opReg, opImm, opLui, opLoad};
    if (executed.opClass == opStore) begin
      retireValue = executed.aluResult;
    end else if (isIllegal) begin
      retireValue = '0;
    end else begin
      retireValue = writeback.data;
    end
  end

  // commits with the register write and the store bytes
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      retire <= '0;
    end else begin
      retire.valid <= executed.valid;
      retire.illegal <= executed.valid && isIllegal;
      retire.rdWe <= writeback.we;
      retire.rd <= executed.rd;
      retire.value <= retireValue;
    end
  end

endmodule

`default_nettype wire

/* hw/rvExecCore.sv */
`timescale 1ns/1ps
`default_nettype none

module rvExecCore import rvCorePkg::*; (
  input  logic              clk,
  input  logic              rstN,
  input  logic              instrValid,
  input  logic [instrW-1:0] instr,
  output retireT            retire
);

  decodedT             decoded;
  executedT            executed;
  writebackT           writeback;
  logic [regAddrW-1:0] rs1;
  logic [regAddrW-1:0] rs2;
  logic [xlen-1:0]     rs1Data;
  logic [xlen-1:0]     rs2Data;
  logic                memWe;
  memSizeE             memSize;
  logic [memAddrW-1:0] memAddr;
  logic [xlen-1:0]     memWriteData;
  logic [xlen-1:0]     memReadData;

  // decode, execute, result, one cycle each
  instrDecoder u_instrDecoder (
    .clk(clk),
    .rstN(rstN),
    .instrValid(instrValid),
    .instr(instr),
    .decoded(decoded)
  );

  registerFile u_registerFile (
    .clk(clk),
    .rstN(rstN),
    .rs1(rs1),
    .rs2(rs2),
    .rs1Data(rs1Data),
    .rs2Data(rs2Data),
    .writeback(writeback)
  );

  aluExecute u_aluExecute (
    .clk(clk),
    .rstN(rstN),
    .decoded(decoded),
    .rs1(rs1),
    .rs2(rs2),
    .rs1Data(rs1Data),
    .rs2Data(rs2Data),
    .executed(executed)
  );

  dataMemory u_dataMemory (
    .clk(clk),
    .we(memWe),
    .size(memSize),
    .addr(memAddr),
    .writeData(memWriteData),
    .readData(memReadData)
  );

  resultStage u_resultStage (
    .clk(clk),
    .rstN(rstN),
    .executed(executed),
    .memWe(memWe),
    .memSize(memSize),
    .memAddr(memAddr),
    .memWriteData(memWriteData),
    .memReadData(memReadData),
    .writeback(writeback),
    .retire(retire)
  );

endmodule

`default_nettype wire

/* tests/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    // reset held over three rising edges
    repeat (3) @(posedge clk);
    // release away from the active edge
    @(negedge clk);
    rstN <= 1'b1;
  end

  // 40 ns period
  always #20 clk = ~clk;

endmodule

`default_nettype wire

/* tests/rvExecCore_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module rvExecCore_properties import rvCorePkg::*; (
  input logic   clk,
  input logic   rstN,
  input logic   instrValid,
  input retireT retire
);

  // fixed latency, one retire per strobe
  assert property (@(posedge clk) disable iff (!rstN)
    retire.valid == $past(instrValid, 3))
    else $error("retire strobe not three cycles after instruction strobe");

  // nothing retires while in reset
  assert property (@(posedge clk) !rstN |-> !retire.valid)
    else $error("retire strobe seen during reset");

  // register write only for legal ops with a real destination
  assert property (@(posedge clk) disable iff (!rstN)
    retire.rdWe |-> (retire.rd != '0 && !retire.illegal))
    else $error("register write flagged for x0 or an illegal instruction");

endmodule

bind rvExecCore rvExecCore_properties u_rvExecCoreProperties (
  .clk(clk),
  .rstN(rstN),
  .instrValid(instrValid),
  .retire(retire)
);

`default_nettype wire

/* tests/rvExecCore_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rvExecCore_tb import rvCorePkg::*; ();

  logic        clk;
  logic        rstN;
  logic        instrValid;
  logic [31:0] instr;
  retireT      retire;

  // reference state updated in issue order
  logic [63:0] refRegs [32];
  logic [7:0]  refMem [memBytes];
  retireT      expQ [$];
  retireT      expected;
  integer      seed = 32'h781c;
  int          stallCycles = 0;

  clockGen u_clockGen (
    .clk(clk),
    .rstN(rstN)
  );

  rvExecCore u_rvExecCore (
    .clk(clk),
    .rstN(rstN),
    .instrValid(instrValid),
    .instr(instr),
    .retire(retire)
  );

  // instruction encoders
  function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, rvOpReg};
  endfunction

  function automatic logic [31:0] iType(input logic [6:0] op, input logic [4:0] rd,
                                        input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] sType(input logic [2:0] f3, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rvOpStore};
  endfunction

  function automatic logic [31:0] uType(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, rvOpLui};
  endfunction

  // predicts one retire and updates the model state
  function automatic retireT predictRetire(input logic [31:0] ins);
    retireT      exp;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [63:0] a, b, immI, immS, addr, val;
    logic        legal, isStore;
    int          n, i;
    rd = ins[11:7];
    rs1 = ins[19:15];
    rs2 = ins[24:20];
    f3 = ins[14:12];
    a = refRegs[rs1];
    b = refRegs[rs2];
    immI = {{52{ins[31]}}, ins[31:20]};
    immS = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    legal = 1'b1;
    isStore = 1'b0;
    val = '0;
    n = 1 << f3[1:0];
    case (ins[6:0])
      rvOpReg: begin
        if (ins[31:25] == 7'h20 && f3 == 3'b000) val = a - b;
        else if (ins[31:25] != 7'h00) legal = 1'b0;
        else begin
          case (f3)
            3'b000: val = a + b;
            3'b010: val = {63'b0, $signed(a) < $signed(b)};
            3'b011: val = {63'b0, a < b};
            3'b100: val = a ^ b;
            3'b110: val = a | b;
            3'b111: val = a & b;
            default: legal = 1'b0;
          endcase
        end
      end
      rvOpImm: begin
        // SLTIU and shifts are not supported
        case (f3)
          3'b000: val = a + immI;
          3'b010: val = {63'b0, $signed(a) < $signed(immI)};
          3'b100: val = a ^ immI;
          3'b110: val = a | immI;
          3'b111: val = a & immI;
          default: legal = 1'b0;
        endcase
      end
      rvOpLui: val = {{32{ins[31]}}, ins[31:12], 12'b0};
      rvOpLoad: begin
        legal = f3 != 3'b111;
        addr = a + immI;
        // first byte is most significant
        for (i = 0; i < n; i++) val = {val[55:0], refMem[(addr + i) % memBytes]};
        if (!f3[2] && val[8*n-1]) val = val | (~64'h0 << (8 * n));
      end
      rvOpStore: begin
        isStore = 1'b1;
        legal = !f3[2];
        addr = a + immS;
        if (legal) begin
          for (i = 0; i < n; i++) refMem[(addr + i) % memBytes] = b[8*(n-1-i) +: 8];
        end
        val = addr;
      end
      default: legal = 1'b0;
    endcase
    exp.valid = 1'b1;
    exp.illegal = !legal;
    exp.rdWe = legal && !isStore && rd != 5'd0;
    exp.rd = isStore ? 5'd0 : rd;
    exp.value = legal ? val : 64'd0;
    if (exp.rdWe) refRegs[rd] = val;
    return exp;
  endfunction

  // memory ops of random instructions stay within 256..319
  function automatic logic [31:0] randomInstr();
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [11:0] off;
    int          sel;
    rd = 5'($random(seed));
    rs1 = 5'($random(seed));
    rs2 = 5'($random(seed));
    f3 = 3'($random(seed));
    off = 12'(256 + $unsigned($random(seed)) % 57);
    sel = $unsigned($random(seed)) % 5;
    case (sel)
      0: return rType((f3 == 3'b000 && rs2[0]) ? funct7Alt : funct7Base, f3, rd, rs1, rs2);
      1: return iType(rvOpImm, rd, f3, rs1, 12'($random(seed)));
      2: return uType(rd, 20'($random(seed)));
      3: return iType(rvOpLoad, rd, f3, 5'd0, off);
      default: return sType({1'b0, f3[1:0]}, rs2, 5'd0, off);
    endcase
  endfunction

  task automatic failRun();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
      failRun();
    end
  endtask

  task automatic issue(input logic [31:0] ins);
    @(posedge clk);
    instrValid <= 1'b1;
    instr <= ins;
    expQ.push_back(predictRetire(ins));
  endtask

  task automatic pause(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      instrValid <= 1'b0;
    end
  endtask

  // retire is stable on the falling edge
  always @(negedge clk) begin
    if (rstN && retire.valid) begin
      if (expQ.size() == 0) begin
        $display("retire seen at %0t with no instruction outstanding", $time);
        failRun();
      end else begin
        expected = expQ.pop_front();
        checkValue("retire.illegal", 64'(retire.illegal), 64'(expected.illegal));
        checkValue("retire.rdWe", 64'(retire.rdWe), 64'(expected.rdWe));
        checkValue("retire.rd", 64'(retire.rd), 64'(expected.rd));
        checkValue("retire.value", retire.value, expected.value);
        stallCycles = 0;
      end
    end else if (expQ.size() != 0) begin
      stallCycles++;
      if (stallCycles > 8) begin
        $display("no retire within 8 cycles while instructions are outstanding");
        failRun();
      end
    end
  end

  initial begin
    int cycles;
    int k;
    instrValid = 1'b0;
    instr = '0;
    foreach (refRegs[i]) refRegs[i] = '0;
    cycles = 0;
    while (!rstN && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (!rstN) begin
      $display("reset was never released");
      failRun();
    end
    pause(3);
    // x1 = -5 and x2 = 7 feed dependent ops every cycle
    issue(iType(rvOpImm, 5'd1, 3'b000, 5'd0, 12'hffb));
    issue(iType(rvOpImm, 5'd2, 3'b000, 5'd0, 12'h007));
    issue(rType(funct7Base, 3'b000, 5'd3, 5'd1, 5'd2));
    issue(rType(funct7Alt, 3'b000, 5'd4, 5'd3, 5'd1));
    issue(rType(funct7Base, 3'b010, 5'd5, 5'd1, 5'd2));
    issue(rType(funct7Base, 3'b011, 5'd6, 5'd1, 5'd2));
    issue(rType(funct7Base, 3'b100, 5'd7, 5'd1, 5'd4));
    issue(rType(funct7Base, 3'b110, 5'd8, 5'd7, 5'd2));
    issue(rType(funct7Base, 3'b111, 5'd9, 5'd8, 5'd1));
    issue(iType(rvOpImm, 5'd10, 3'b010, 5'd1, 12'hfff));
    issue(iType(rvOpImm, 5'd11, 3'b100, 5'd10, 12'h8a5));
    issue(iType(rvOpImm, 5'd12, 3'b110, 5'd11, 12'h0f0));
    issue(iType(rvOpImm, 5'd13, 3'b111, 5'd12, 12'hf0f));
    // upper immediates with the sign bit set and negative addi
    issue(uType(5'd14, 20'h80000));
    issue(uType(5'd15, 20'h12345));
    issue(iType(rvOpImm, 5'd15, 3'b000, 5'd15, 12'h800));
    issue(iType(rvOpImm, 5'd16, 3'b000, 5'd14, 12'hfff));
    pause(2);
    // fill the whole window with doublewords
    for (k = 0; k < 8; k++) issue(sType(3'b011, 5'(9 + k), 5'd0, 12'(256 + 8 * k)));
    issue(sType(3'b000, 5'd14, 5'd0, 12'd257));
    issue(sType(3'b001, 5'd16, 5'd0, 12'd262));
    issue(sType(3'b010, 5'd15, 5'd0, 12'd268));
    // every load size and signedness
    for (k = 0; k < 7; k++) issue(iType(rvOpLoad, 5'(17 + k), 3'(k), 5'd0, 12'(257 + k)));
    // doubleword across the end of memory
    issue(sType(3'b011, 5'd16, 5'd0, 12'd2044));
    issue(iType(rvOpLoad, 5'd24, 3'b011, 5'd0, 12'd2044));
    issue(iType(rvOpLoad, 5'd25, 3'b010, 5'd0, 12'd2046));
    issue(iType(rvOpLoad, 5'd26, 3'b100, 5'd0, 12'd2047));
    // x0 stays zero
    issue(iType(rvOpImm, 5'd0, 3'b000, 5'd1, 12'h005));
    issue(rType(funct7Base, 3'b000, 5'd27, 5'd0, 5'd0));
    // illegal branch opcode and SLTIU leave x3 intact
    issue(iType(7'b1100011, 5'd3, 3'b000, 5'd1, 12'h002));
    issue(iType(rvOpImm, 5'd3, 3'b011, 5'd1, 12'h001));
    issue(rType(funct7Base, 3'b000, 5'd28, 5'd3, 5'd0));
    pause(3);
    // full-rate burst followed by random gaps
    repeat (40) issue(randomInstr());
    pause(2);
    repeat (40) begin
      issue(randomInstr());
      pause($unsigned($random(seed)) % 4);
    end
    pause(1);
    cycles = 0;
    while (expQ.size() != 0 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (expQ.size() != 0) begin
      $display("timed out with %0d instructions not retired", expQ.size());
      failRun();
    end else begin
      // quiet tail with no strobes
      repeat (5) @(posedge clk);
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* flist.f */
hw/rvCorePkg.sv
hw/instrDecoder.sv
hw/registerFile.sv
hw/aluExecute.sv
hw/dataMemory.sv
hw/resultStage.sv
hw/rvExecCore.sv
tests/clockGen.sv
tests/rvExecCore_properties.sv
tests/rvExecCore_tb.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module rvExecCore_tb -o simv; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
